//--- i3c_regf_pkg.sv
/*
 * Register file sizes, byte address map and reset default table
 * Bank write request and decoded command structs
 * Descriptor word 0 union with regular and immediate views
 */
`default_nettype none

package i3c_regf_pkg;

  ////////////////////
  // Sizes
  localparam int REGF_WIDTH     = 8;                          // Data byte
  localparam int REGF_ADDR_W    = 9;                          // 512 bytes
  localparam int REGF_NUM_BANKS = 8;                          // Low address bits pick the bank
  localparam int REGF_ROWS      = 64;                         // Upper address bits pick the row
  localparam int REGF_BANK_W    = $clog2(REGF_NUM_BANKS);
  localparam int REGF_ROW_W     = $clog2(REGF_ROWS);
  localparam int REGF_DESC_W    = REGF_NUM_BANKS * REGF_WIDTH; // One descriptor row, 64 bits

  ////////////////////
  // Address map
  localparam logic [REGF_ADDR_W-1:0] ADDR_TARGET      = 9'd0;   // Target address, bit 0 is RnW
  localparam logic [REGF_ADDR_W-1:0] ADDR_NUM_FRAMES  = 9'd1;
  localparam logic [REGF_ADDR_W-1:0] ADDR_BDCST_WR    = 9'd46;  // 7'h7E + W
  localparam logic [REGF_ADDR_W-1:0] ADDR_BDCST_RD    = 9'd47;  // 7'h7E + R
  localparam logic [REGF_ADDR_W-1:0] ADDR_ARBITRATION = 9'd48;
  localparam logic [REGF_ADDR_W-1:0] ADDR_ENEC_BYTE   = 9'd402; // ENINT, ENCR, ENHJ
  localparam logic [REGF_ADDR_W-1:0] ADDR_DISEC_BYTE  = 9'd404; // DISINT, DISCR, DISHJ
  localparam logic [REGF_ADDR_W-1:0] ADDR_HJ_CFG      = 9'd405;
  localparam logic [REGF_ADDR_W-1:0] ADDR_CRCAP1      = 9'd409;
  localparam logic [REGF_ROW_W-1:0]  ROW_DUMMY_CFG    = 6'd56;  // Fixed dummy descriptor row
  localparam int ADDR_DUMMY_CFG = ROW_DUMMY_CFG * REGF_NUM_BANKS; // Byte 448

  localparam int HJ_DEF_BIT = 3; // ENHJ / DISHJ position in the event bytes

  // Reset value of any byte address
  function automatic logic [REGF_WIDTH-1:0] regf_default(input int unsigned addr);
    logic [REGF_WIDTH-1:0] val;
    case (addr)
      ADDR_TARGET        : val = 8'hA8;
      ADDR_NUM_FRAMES    : val = 8'h02;
      ADDR_BDCST_WR      : val = 8'hFC;
      ADDR_BDCST_RD      : val = 8'hFD;
      ADDR_ARBITRATION   : val = 8'h53;
      ADDR_ENEC_BYTE     : val = 8'h0B; // Hot-join enabled by default
      ADDR_DISEC_BYTE    : val = 8'h00;
      ADDR_HJ_CFG        : val = 8'h07;
      ADDR_CRCAP1        : val = 8'h01; // Hot-join supported
      ADDR_DUMMY_CFG     : val = 8'h81; // Immediate, attr bit 0 set
      ADDR_DUMMY_CFG + 1 : val = 8'h8F;
      ADDR_DUMMY_CFG + 2 : val = 8'h00;
      ADDR_DUMMY_CFG + 3 : val = 8'h18;
      default            : val = '0;
    endcase
    return val;
  endfunction

  ////////////////////
  // Types
  typedef struct packed {
    logic                  vld;  // Write this bank on the edge
    logic [REGF_ROW_W-1:0] row;
    logic [REGF_WIDTH-1:0] data;
  } regf_wr_t;

  // Descriptor word 0, regular transfer
  typedef struct packed {
    logic       toc;
    logic       wroc;
    logic       rnw;
    logic [2:0] mode;
    logic       dbp;      // Defining byte present
    logic       sre;      // Short read
    logic [2:0] rsvd;
    logic [4:0] dev_index;
    logic       cp;
    logic [7:0] cmd;
    logic [3:0] tid;
    logic [2:0] cmd_attr;
  } regular_t;

  // Descriptor word 0, immediate transfer
  typedef struct packed {
    logic       toc;
    logic       wroc;
    logic       rnw;
    logic [2:0] mode;
    logic [2:0] dtt;      // Data byte count of the immediate
    logic [1:0] rsvd;
    logic [4:0] dev_index;
    logic       cp;
    logic [7:0] cmd;
    logic [3:0] tid;
    logic [2:0] cmd_attr;
  } immediate_t;

  typedef union packed {
    regular_t   regular;
    immediate_t immediate;
  } regf_dword0_u;

  typedef struct packed {
    logic [15:0] data_len;
    logic [2:0]  cmd_attr;
    logic [3:0]  tid;
    logic [7:0]  ccc_cmd;
    logic [4:0]  dev_index;
    logic [2:0]  dtt;
    logic [2:0]  mode;
    logic        rnw;
    logic        wroc;
    logic        toc;
    logic        cp;
    logic        dbp;
    logic        sre;
  } regf_cmd_t;

endpackage

`default_nettype wire

//--- regf_write_ctrl.sv
/*
 * Strobe decode of the controller requests
 * Turns a lone write enable into a write to one bank, qualifies reads
 */
`timescale 1ns/10ps
`default_nettype none

module regf_write_ctrl #(
  parameter int NUM_BANKS = i3c_regf_pkg::REGF_NUM_BANKS
) (
  input  wire logic                                  i_regf_clk,
  input  wire logic                                  i_regf_rst_n,
  input  wire logic                                  i_regf_rd_en,   // Read strobe
  input  wire logic                                  i_regf_wr_en,   // Write strobe
  input  wire logic [i3c_regf_pkg::REGF_ADDR_W-1:0]  i_regf_addr,
  input  wire logic [i3c_regf_pkg::REGF_WIDTH-1:0]   i_regf_wr_data,
  output logic                                       o_rd_req,       // Read accepted this edge
  output i3c_regf_pkg::regf_wr_t                     o_bank_wr [NUM_BANKS]
);

  localparam int BANK_W = i3c_regf_pkg::REGF_BANK_W;
  localparam int ADDR_W = i3c_regf_pkg::REGF_ADDR_W;

  logic                 wr_req;             // Write alone on the strobes
  logic [BANK_W-1:0]    wr_bank;            // Low address bits
  logic [ADDR_W-BANK_W-1:0] wr_row;         // Upper address bits
  logic [NUM_BANKS-1:0] wr_hit;             // One-hot bank select

  // Both strobes high drops the request
  assign wr_req   = i_regf_wr_en & ~i_regf_rd_en;
  assign o_rd_req = i_regf_rd_en & ~i_regf_wr_en;

  assign wr_bank = i_regf_addr[BANK_W-1:0];
  assign wr_row  = i_regf_addr[ADDR_W-1:BANK_W];

  always_comb
  begin
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      wr_hit[b]         = wr_req && (wr_bank == b);
      o_bank_wr[b].vld  = wr_hit[b];
      o_bank_wr[b].row  = wr_row;          // Row and data shared by all banks
      o_bank_wr[b].data = i_regf_wr_data;
    end
  end

  ////////////////////
  // Checks
  a_one_bank: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    $onehot0(wr_hit))
    else $error("write decoded to more than one bank");

  a_strobe_excl: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    !(i_regf_rd_en && i_regf_wr_en))
    else $warning("rd_en and wr_en both high, request dropped");

endmodule

`default_nettype wire

//--- regf_bank.sv
/*
 * One bank of byte rows with per-address reset defaults
 * Single write port, combinational read and descriptor ports
 */
`timescale 1ns/10ps
`default_nettype none

module regf_bank #(
  parameter int BANK_IDX  = 0,                               // Low address bits of this bank
  parameter int NUM_BANKS = i3c_regf_pkg::REGF_NUM_BANKS,
  parameter int ROWS      = i3c_regf_pkg::REGF_ROWS
) (
  input  wire logic                                 i_regf_clk,
  input  wire logic                                 i_regf_rst_n,
  input  wire i3c_regf_pkg::regf_wr_t               i_wr,        // From the write decode
  input  wire logic [i3c_regf_pkg::REGF_ROW_W-1:0]  i_rd_row,    // Controller read row
  input  wire logic [i3c_regf_pkg::REGF_ROW_W-1:0]  i_cfg_row,   // Engine descriptor row
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]       o_rd_byte,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]       o_cfg_byte
);

  localparam int W = i3c_regf_pkg::REGF_WIDTH;

  logic [W-1:0] mem [ROWS]; // Row r holds byte r*NUM_BANKS+BANK_IDX

  ////////////////////
  // Storage
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      // Every byte loads its own default
      for (int r = 0; r < ROWS; r++)
      begin
        mem[r] <= i3c_regf_pkg::regf_default(r * NUM_BANKS + BANK_IDX);
      end
    end
    else if (i_wr.vld)
    begin
      mem[i_wr.row] <= i_wr.data;  // Takes effect on the strobe edge
    end
  end

  ////////////////////
  // Read ports
  assign o_rd_byte  = mem[i_rd_row];   // Registered in the read path
  assign o_cfg_byte = mem[i_cfg_row];  // One byte of the descriptor row

endmodule

`default_nettype wire

//--- regf_hotjoin.sv
/*
 * Hot-join configuration and capability shadow registers
 * Drives the ENHJ defining bit and the hot-join status outputs
 */
`timescale 1ns/10ps
`default_nettype none

module regf_hotjoin #(
  parameter int NUM_BANKS = i3c_regf_pkg::REGF_NUM_BANKS
) (
  input  wire logic                   i_regf_clk,
  input  wire logic                   i_regf_rst_n,
  input  wire i3c_regf_pkg::regf_wr_t i_bank_wr [NUM_BANKS], // Decoded writes, snooped
  output logic                        o_enhj,                // DISHJ is the inverse
  output logic [2:0]                  o_regf_hj_cfg,
  output logic                        o_regf_hj_support
);

  // Bank and row of the two snooped bytes
  localparam int HJ_BANK  = i3c_regf_pkg::ADDR_HJ_CFG % NUM_BANKS;
  localparam int HJ_ROW   = i3c_regf_pkg::ADDR_HJ_CFG / NUM_BANKS;
  localparam int CAP_BANK = i3c_regf_pkg::ADDR_CRCAP1 % NUM_BANKS;
  localparam int CAP_ROW  = i3c_regf_pkg::ADDR_CRCAP1 / NUM_BANKS;

  localparam logic [7:0] HJ_CFG_RST = i3c_regf_pkg::regf_default(i3c_regf_pkg::ADDR_HJ_CFG);
  localparam logic [7:0] CRCAP1_RST = i3c_regf_pkg::regf_default(i3c_regf_pkg::ADDR_CRCAP1);

  logic       hj_cfg_wr;  // Write hits HJ_CFG
  logic       cap_wr;     // Write hits CRCAP1
  logic [2:0] hj_cfg_q;
  logic       hj_cap_q;   // CRCAP1 bit 0, hot-join supported

  assign hj_cfg_wr = i_bank_wr[HJ_BANK].vld && (i_bank_wr[HJ_BANK].row == HJ_ROW);
  assign cap_wr    = i_bank_wr[CAP_BANK].vld && (i_bank_wr[CAP_BANK].row == CAP_ROW);

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      hj_cfg_q <= HJ_CFG_RST[2:0];
      hj_cap_q <= CRCAP1_RST[0];
    end
    else
    begin
      if (hj_cfg_wr) hj_cfg_q <= i_bank_wr[HJ_BANK].data[2:0];
      if (cap_wr)    hj_cap_q <= i_bank_wr[CAP_BANK].data[0];
    end
  end

  assign o_enhj            = hj_cap_q & hj_cfg_q[1]; // Supported and enabled
  assign o_regf_hj_cfg     = hj_cfg_q;
  assign o_regf_hj_support = hj_cap_q;

endmodule

`default_nettype wire

//--- regf_read_path.sv
/*
 * Read data register with the ENHJ / DISHJ override
 * Gathers the descriptor bytes of all banks into one row
 */
`timescale 1ns/10ps
`default_nettype none

module regf_read_path #(
  parameter int NUM_BANKS = i3c_regf_pkg::REGF_NUM_BANKS
) (
  input  wire logic                                   i_regf_clk,
  input  wire logic                                   i_regf_rst_n,
  input  wire logic                                   i_rd_req,     // Read accepted this edge
  input  wire logic [i3c_regf_pkg::REGF_ADDR_W-1:0]   i_regf_addr,
  input  wire logic [i3c_regf_pkg::REGF_WIDTH-1:0]    i_rd_bytes  [NUM_BANKS],
  input  wire logic [i3c_regf_pkg::REGF_WIDTH-1:0]    i_cfg_bytes [NUM_BANKS],
  input  wire logic                                   i_enhj,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]         o_regf_data_rd,
  output logic [NUM_BANKS*i3c_regf_pkg::REGF_WIDTH-1:0] o_cfg_row_data
);

  localparam int W      = i3c_regf_pkg::REGF_WIDTH;
  localparam int BANK_W = i3c_regf_pkg::REGF_BANK_W;
  localparam int HJ_BIT = i3c_regf_pkg::HJ_DEF_BIT;

  logic [W-1:0] rd_byte;  // Byte of the addressed bank
  logic [W-1:0] rd_data;  // After the defining-bit override

  assign rd_byte = i_rd_bytes[i_regf_addr[BANK_W-1:0]];

  ////////////////////
  // Hot-join defining bits
  always_comb
  begin
    rd_data = rd_byte;
    if (i_regf_addr == i3c_regf_pkg::ADDR_ENEC_BYTE)
    begin
      rd_data[HJ_BIT] = i_enhj;       // ENHJ
    end
    else if (i_regf_addr == i3c_regf_pkg::ADDR_DISEC_BYTE)
    begin
      rd_data[HJ_BIT] = ~i_enhj;      // DISHJ
    end
  end

  // Holds until the next accepted read
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_regf_data_rd <= '0;
    end
    else if (i_rd_req)
    begin
      o_regf_data_rd <= rd_data;
    end
  end

  ////////////////////
  // Descriptor row
  always_comb
  begin
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      o_cfg_row_data[b*W +: W] = i_cfg_bytes[b]; // Bank 0 is the LSB
    end
  end

endmodule

`default_nettype wire

//--- regf_cmd_decode.sv
/*
 * Command descriptor decode
 * Word 0 read as regular or immediate by CMD_ATTR bit 0, registered fields out
 */
`timescale 1ns/10ps
`default_nettype none

module regf_cmd_decode (
  input  wire logic                                 i_regf_clk,
  input  wire logic                                 i_regf_rst_n,
  input  wire logic [i3c_regf_pkg::REGF_DESC_W-1:0] i_cfg_row_data, // Two 32-bit words
  output i3c_regf_pkg::regf_cmd_t                   o_regf_cmd
);

  localparam int DLEN_LSB = 48;  // data_len is word 1 bits 31:16

  i3c_regf_pkg::regf_dword0_u dword0;
  i3c_regf_pkg::regf_cmd_t    cmd_d;   // Decoded, before the register

  assign dword0 = i_cfg_row_data[31:0];

  ////////////////////
  // Decode
  always_comb
  begin
    cmd_d          = '0;
    cmd_d.data_len = i_cfg_row_data[DLEN_LSB +: 16];
    if (dword0.regular.cmd_attr[0])
    begin
      // Immediate, DTT carries the byte count
      cmd_d.cmd_attr  = dword0.immediate.cmd_attr;
      cmd_d.tid       = dword0.immediate.tid;
      cmd_d.ccc_cmd   = dword0.immediate.cmd;
      cmd_d.cp        = dword0.immediate.cp;
      cmd_d.dev_index = dword0.immediate.dev_index;
      cmd_d.dtt       = dword0.immediate.dtt;
      cmd_d.mode      = dword0.immediate.mode;
      cmd_d.rnw       = dword0.immediate.rnw;
      cmd_d.wroc      = dword0.immediate.wroc;
      cmd_d.toc       = dword0.immediate.toc;
      cmd_d.dbp       = 1'b0;
      cmd_d.sre       = 1'b0;
    end
    else
    begin
      // Regular, no DTT
      cmd_d.cmd_attr  = dword0.regular.cmd_attr;
      cmd_d.tid       = dword0.regular.tid;
      cmd_d.ccc_cmd   = dword0.regular.cmd;
      cmd_d.cp        = dword0.regular.cp;
      cmd_d.dev_index = dword0.regular.dev_index;
      cmd_d.dtt       = 3'd0;
      cmd_d.mode      = dword0.regular.mode;
      cmd_d.rnw       = dword0.regular.rnw;
      cmd_d.wroc      = dword0.regular.wroc;
      cmd_d.toc       = dword0.regular.toc;
      cmd_d.dbp       = dword0.regular.dbp;
      cmd_d.sre       = dword0.regular.sre;
    end
  end

  ////////////////////
  // Output register
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_regf_cmd <= '0;
    end
    else
    begin
      o_regf_cmd <= cmd_d;  // Follows the row one cycle later
    end
  end

endmodule

`default_nettype wire

//--- i3c_regf_top.sv
/*
 * I3C controller register file, top level
 * Write decode, banked storage, hot-join bits, read path and command decode
 */
`timescale 1ns/10ps
`default_nettype none

module i3c_regf_top #(
  parameter int NUM_BANKS = i3c_regf_pkg::REGF_NUM_BANKS,
  parameter int ROWS      = i3c_regf_pkg::REGF_ROWS
) (
  input  wire logic                                 i_regf_clk,
  input  wire logic                                 i_regf_rst_n,
  input  wire logic                                 i_regf_rd_en,
  input  wire logic                                 i_regf_wr_en,
  input  wire logic [i3c_regf_pkg::REGF_ADDR_W-1:0] i_regf_addr,
  input  wire logic [i3c_regf_pkg::REGF_WIDTH-1:0]  i_regf_wr_data,
  input  wire logic [i3c_regf_pkg::REGF_ROW_W-1:0]  i_engine_cfg_row, // Descriptor row index
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]       o_regf_data_rd,
  output i3c_regf_pkg::regf_cmd_t                   o_regf_cmd,
  output logic [2:0]                                o_regf_hj_cfg,
  output logic                                      o_regf_hj_support
);

  localparam int W      = i3c_regf_pkg::REGF_WIDTH;
  localparam int ADDR_W = i3c_regf_pkg::REGF_ADDR_W;
  localparam int BANK_W = i3c_regf_pkg::REGF_BANK_W;

  i3c_regf_pkg::regf_wr_t bank_wr [NUM_BANKS];        // One write port per bank
  logic                   rd_req;
  logic [W-1:0]           rd_bytes  [NUM_BANKS];
  logic [W-1:0]           cfg_bytes [NUM_BANKS];
  logic                   enhj;
  logic [i3c_regf_pkg::REGF_DESC_W-1:0] cfg_row_data;  // Selected descriptor

  regf_write_ctrl #(.NUM_BANKS(NUM_BANKS)) u_write_ctrl (
    .i_regf_clk     (i_regf_clk),
    .i_regf_rst_n   (i_regf_rst_n),
    .i_regf_rd_en   (i_regf_rd_en),
    .i_regf_wr_en   (i_regf_wr_en),
    .i_regf_addr    (i_regf_addr),
    .i_regf_wr_data (i_regf_wr_data),
    .o_rd_req       (rd_req),
    .o_bank_wr      (bank_wr)
  );

  ////////////////////
  // Storage banks
  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    regf_bank #(.BANK_IDX(b), .NUM_BANKS(NUM_BANKS), .ROWS(ROWS)) u_bank (
      .i_regf_clk   (i_regf_clk),
      .i_regf_rst_n (i_regf_rst_n),
      .i_wr         (bank_wr[b]),
      .i_rd_row     (i_regf_addr[ADDR_W-1:BANK_W]),
      .i_cfg_row    (i_engine_cfg_row),
      .o_rd_byte    (rd_bytes[b]),
      .o_cfg_byte   (cfg_bytes[b])
    );
  end

  regf_hotjoin #(.NUM_BANKS(NUM_BANKS)) u_hotjoin (
    .i_regf_clk        (i_regf_clk),
    .i_regf_rst_n      (i_regf_rst_n),
    .i_bank_wr         (bank_wr),
    .o_enhj            (enhj),
    .o_regf_hj_cfg     (o_regf_hj_cfg),
    .o_regf_hj_support (o_regf_hj_support)
  );

  regf_read_path #(.NUM_BANKS(NUM_BANKS)) u_read_path (
    .i_regf_clk     (i_regf_clk),
    .i_regf_rst_n   (i_regf_rst_n),
    .i_rd_req       (rd_req),
    .i_regf_addr    (i_regf_addr),
    .i_rd_bytes     (rd_bytes),
    .i_cfg_bytes    (cfg_bytes),
    .i_enhj         (enhj),
    .o_regf_data_rd (o_regf_data_rd),
    .o_cfg_row_data (cfg_row_data)
  );

  regf_cmd_decode u_cmd_decode (
    .i_regf_clk     (i_regf_clk),
    .i_regf_rst_n   (i_regf_rst_n),
    .i_cfg_row_data (cfg_row_data),
    .o_regf_cmd     (o_regf_cmd)
  );

endmodule

`default_nettype wire

//--- tb_i3c_regf.sv
/*
 * Testbench for the I3C register file
 * Byte reference model, strobe stimulus on the falling edge
 * Concurrent checks on read data, command decode and hot-join status
 */
`timescale 1ns/10ps
`default_nettype none

module tb_i3c_regf;

  localparam int TIMEOUT = 20;  // Cycles allowed per wait

  logic                                 i_regf_clk;
  logic                                 i_regf_rst_n;
  logic                                 i_regf_rd_en;
  logic                                 i_regf_wr_en;
  logic [i3c_regf_pkg::REGF_ADDR_W-1:0] i_regf_addr;
  logic [i3c_regf_pkg::REGF_WIDTH-1:0]  i_regf_wr_data;
  logic [i3c_regf_pkg::REGF_ROW_W-1:0]  i_engine_cfg_row;
  logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_regf_data_rd;
  i3c_regf_pkg::regf_cmd_t              o_regf_cmd;
  logic [2:0]                           o_regf_hj_cfg;
  logic                                 o_regf_hj_support;

  logic [7:0]              ref_mem [512];  // Expected contents, one entry per byte
  logic [7:0]              rd_exp_q;       // Expected read data, one cycle behind
  i3c_regf_pkg::regf_cmd_t cmd_exp_q;      // Expected command fields
  logic [8:0]              wr_addrs [$];   // Addresses of the random writes
  int                      err_count;
  int                      test_count;
  int                      rd_count;
  int                      wr_count;

  i3c_regf_top #(
    .NUM_BANKS (i3c_regf_pkg::REGF_NUM_BANKS),
    .ROWS      (i3c_regf_pkg::REGF_ROWS)
  ) UUT (
    .i_regf_clk        (i_regf_clk),
    .i_regf_rst_n      (i_regf_rst_n),
    .i_regf_rd_en      (i_regf_rd_en),
    .i_regf_wr_en      (i_regf_wr_en),
    .i_regf_addr       (i_regf_addr),
    .i_regf_wr_data    (i_regf_wr_data),
    .i_engine_cfg_row  (i_engine_cfg_row),
    .o_regf_data_rd    (o_regf_data_rd),
    .o_regf_cmd        (o_regf_cmd),
    .o_regf_hj_cfg     (o_regf_hj_cfg),
    .o_regf_hj_support (o_regf_hj_support)
  );

  always #50 i_regf_clk = ~i_regf_clk;  // 100 ns period

  ////////////////////
  // Reference model
  function automatic logic [7:0] reset_value(input int addr);
    case (addr)
      0       : return 8'hA8;
      1       : return 8'h02;
      46      : return 8'hFC;
      47      : return 8'hFD;
      48      : return 8'h53;
      402     : return 8'h0B;
      405     : return 8'h07;
      409     : return 8'h01;
      448     : return 8'h81;  // Dummy descriptor, immediate
      449     : return 8'h8F;
      451     : return 8'h18;
      default : return 8'h00;
    endcase
  endfunction

  // ENHJ and DISHJ replace bit 3 of the event bytes
  function automatic logic [7:0] read_model(input logic [8:0] addr);
    logic [7:0] val;
    logic       enhj;
    enhj = ref_mem[i3c_regf_pkg::ADDR_HJ_CFG][1] & ref_mem[i3c_regf_pkg::ADDR_CRCAP1][0];
    val  = ref_mem[addr];
    if (addr == i3c_regf_pkg::ADDR_ENEC_BYTE)
      val[3] = enhj;
    else if (addr == i3c_regf_pkg::ADDR_DISEC_BYTE)
      val[3] = ~enhj;
    return val;
  endfunction

  function automatic i3c_regf_pkg::regf_cmd_t decode_row(input logic [5:0] row);
    i3c_regf_pkg::regf_cmd_t cmd;
    logic [31:0]             w0;
    logic [31:0]             w1;
    int                      base;
    base = int'(row) * 8;
    w0   = {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
    w1   = {ref_mem[base+7], ref_mem[base+6], ref_mem[base+5], ref_mem[base+4]};
    cmd           = '0;
    cmd.data_len  = w1[31:16];
    cmd.cmd_attr  = w0[2:0];
    cmd.tid       = w0[6:3];
    cmd.ccc_cmd   = w0[14:7];
    cmd.cp        = w0[15];
    cmd.dev_index = w0[20:16];
    cmd.mode      = w0[28:26];
    cmd.rnw       = w0[29];
    cmd.wroc      = w0[30];
    cmd.toc       = w0[31];
    if (w0[0])
      cmd.dtt = w0[25:23];  // Immediate, no DBP or SRE
    else
    begin
      cmd.dbp = w0[25];
      cmd.sre = w0[24];
    end
    return cmd;
  endfunction

  // Follows the strobes the same way the register file does
  always @(posedge i_regf_clk)
  begin
    if (i_regf_rst_n && i_regf_wr_en && !i_regf_rd_en)
      ref_mem[i_regf_addr] <= i_regf_wr_data;
    if (i_regf_rst_n && i_regf_rd_en && !i_regf_wr_en)
      rd_exp_q <= read_model(i_regf_addr);
    cmd_exp_q <= decode_row(i_engine_cfg_row);
  end

  ////////////////////
  // Checks
  task automatic value_error(input string what, input logic [63:0] got, input logic [63:0] exp);
    err_count++;
    $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
  endtask

  a_rst_data: assert property (@(posedge i_regf_clk)
    $rose(i_regf_rst_n) |-> (o_regf_data_rd == '0))
    else value_error("read data after reset", $sampled(o_regf_data_rd), 0);

  a_rst_cmd: assert property (@(posedge i_regf_clk)
    $rose(i_regf_rst_n) |-> (o_regf_cmd == '0))
    else value_error("command after reset", $sampled(o_regf_cmd), 0);

  a_rd_data: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    (i_regf_rd_en && !i_regf_wr_en) |=> (o_regf_data_rd == rd_exp_q))
    else value_error("read data", $sampled(o_regf_data_rd), $sampled(rd_exp_q));

  // No accepted read, no change
  a_rd_hold: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    !(i_regf_rd_en && !i_regf_wr_en) |=> $stable(o_regf_data_rd))
    else value_error("held read data", $sampled(o_regf_data_rd), $past(o_regf_data_rd));

  a_cmd: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    $past(i_regf_rst_n) |-> (o_regf_cmd == cmd_exp_q))
    else value_error("command fields", $sampled(o_regf_cmd), $sampled(cmd_exp_q));

  a_hj: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    (o_regf_hj_cfg == ref_mem[i3c_regf_pkg::ADDR_HJ_CFG][2:0]) &&
    (o_regf_hj_support == ref_mem[i3c_regf_pkg::ADDR_CRCAP1][0]))
    else value_error("hot-join status", {$sampled(o_regf_hj_cfg), $sampled(o_regf_hj_support)},
      {$sampled(ref_mem[i3c_regf_pkg::ADDR_HJ_CFG][2:0]),
       $sampled(ref_mem[i3c_regf_pkg::ADDR_CRCAP1][0])});

  ////////////////////
  // Stimulus tasks
  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++)
      @(negedge i_regf_clk);
  endtask

  task automatic write_byte(input logic [8:0] addr, input logic [7:0] data);
    @(negedge i_regf_clk);
    i_regf_rd_en   = 1'b0;
    i_regf_wr_en   = 1'b1;
    i_regf_addr    = addr;
    i_regf_wr_data = data;
    wr_count++;
  endtask

  task automatic write_word(input logic [8:0] addr, input logic [31:0] word);
    for (int k = 0; k < 4; k++)
      write_byte(addr + 9'(k), word[8*k +: 8]);  // LSB first
  endtask

  task automatic read_byte(input logic [8:0] addr);
    @(negedge i_regf_clk);
    i_regf_rd_en = 1'b1;
    i_regf_wr_en = 1'b0;
    i_regf_addr  = addr;
    rd_count++;
  endtask

  task automatic drive_both_strobes(input logic [8:0] addr, input logic [7:0] data);
    @(negedge i_regf_clk);
    i_regf_rd_en   = 1'b1;  // Dropped by the DUT
    i_regf_wr_en   = 1'b1;
    i_regf_addr    = addr;
    i_regf_wr_data = data;
  endtask

  task automatic go_idle();
    @(negedge i_regf_clk);
    i_regf_rd_en = 1'b0;
    i_regf_wr_en = 1'b0;
  endtask

  task automatic select_row(input logic [5:0] row);
    @(negedge i_regf_clk);
    i_engine_cfg_row = row;
  endtask

  task automatic wait_cmd_settle();
    bit settled;
    settled = 1'b0;
    for (int i = 0; i < TIMEOUT && !settled; i++)
    begin
      @(negedge i_regf_clk);
      settled = (o_regf_cmd == decode_row(i_engine_cfg_row));
    end
    if (!settled)
      abort_run("command fields never matched the selected descriptor row");
  endtask

  task automatic wait_hj_settle();
    bit settled;
    settled = 1'b0;
    for (int i = 0; i < TIMEOUT && !settled; i++)
    begin
      @(negedge i_regf_clk);
      settled = (o_regf_hj_cfg == ref_mem[i3c_regf_pkg::ADDR_HJ_CFG][2:0]) &&
                (o_regf_hj_support == ref_mem[i3c_regf_pkg::ADDR_CRCAP1][0]);
    end
    if (!settled)
      abort_run("hot-join status never followed the written bytes");
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("test %0d %s done, errors so far %0d", test_count, name, err_count);
  endtask

  ////////////////////
  // Test sequence
  initial
  begin
    logic [8:0] addr;
    logic [8:0] dflt_addrs [9];
    void'($urandom(32'h26b0f9ea));
    i_regf_clk       = 1'b0;
    i_regf_rst_n     = 1'b0;
    i_regf_rd_en     = 1'b0;
    i_regf_wr_en     = 1'b0;
    i_regf_addr      = '0;
    i_regf_wr_data   = '0;
    i_engine_cfg_row = '0;
    rd_exp_q         = '0;
    err_count        = 0;
    test_count       = 0;
    rd_count         = 0;
    wr_count         = 0;
    for (int a = 0; a < 512; a++)
      ref_mem[a] = reset_value(a);
    wait_cycles(5);               // Reset held for 5 cycles
    i_regf_rst_n = 1'b1;

    // Defaults and untouched bytes
    dflt_addrs = '{9'd0, 9'd1, 9'd46, 9'd47, 9'd48, 9'd448, 9'd449, 9'd450, 9'd451};
    foreach (dflt_addrs[i])
      read_byte(dflt_addrs[i]);
    read_byte(9'd2);
    read_byte(9'd100);
    read_byte(9'd333);
    read_byte(9'd511);
    go_idle();
    wait_cycles(2);
    report_test("reset defaults");

    // Random writes kept away from the dummy descriptor row
    for (int i = 0; i < 16; i++)
    begin
      addr = 9'd2 + 9'($urandom % 398);
      write_byte(addr, 8'($urandom));
      wr_addrs.push_back(addr);
    end
    foreach (wr_addrs[i])
      read_byte(wr_addrs[i]);     // Back to back, one per cycle
    drive_both_strobes(wr_addrs[0], ~ref_mem[wr_addrs[0]]);
    read_byte(wr_addrs[0]);
    go_idle();
    wait_cycles(2);
    report_test("random writes and reads");

    select_row(i3c_regf_pkg::ROW_DUMMY_CFG);
    wait_cmd_settle();
    wait_cycles(2);
    report_test("dummy descriptor decode");

    // Regular then immediate descriptor in row 10
    select_row(6'd10);
    write_word(9'd80, 32'h6B85_2A4A);
    write_word(9'd84, 32'h0123_5A5A);
    go_idle();
    wait_cmd_settle();
    write_word(9'd80, 32'hD6A9_3B17);
    write_word(9'd84, 32'h7C41_0055);
    go_idle();
    wait_cmd_settle();
    wait_cycles(2);
    report_test("regular and immediate descriptors");

    // CRCAP1 bit 0 and HJ_CFG bit 1 in all four combinations
    for (int c = 0; c < 4; c++)
    begin
      write_byte(i3c_regf_pkg::ADDR_HJ_CFG, (8'($urandom) & 8'hFD) | {6'd0, c[1], 1'b0});
      write_byte(i3c_regf_pkg::ADDR_CRCAP1, (8'($urandom) & 8'hFE) | {7'd0, c[0]});
      go_idle();
      wait_hj_settle();
      read_byte(i3c_regf_pkg::ADDR_ENEC_BYTE);
      read_byte(i3c_regf_pkg::ADDR_DISEC_BYTE);
      read_byte(i3c_regf_pkg::ADDR_HJ_CFG);
      read_byte(i3c_regf_pkg::ADDR_CRCAP1);
      go_idle();
    end
    wait_cycles(2);
    report_test("hot-join defining bits");

    $display("tests %0d, writes %0d, reads %0d, errors %0d",
             test_count, wr_count, rd_count, err_count);
    if (err_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- i3c_regf.f
i3c_regf_pkg.sv
regf_write_ctrl.sv
regf_bank.sv
regf_hotjoin.sv
regf_read_path.sv
regf_cmd_decode.sv
i3c_regf_top.sv
tb_i3c_regf.sv

//--- Bender.yml
package:
  name: i3c_regf

sources:
  - i3c_regf_pkg.sv
  - regf_write_ctrl.sv
  - regf_bank.sv
  - regf_hotjoin.sv
  - regf_read_path.sv
  - regf_cmd_decode.sv
  - i3c_regf_top.sv
  - target: simulation
    files:
      - tb_i3c_regf.sv
